//--- Bender.yml
package:
  name: core

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/core_pkg.sv
      - hdl/fetch_unit.sv
      - hdl/register_file.sv
      - hdl/branch_predictor.sv
      - hdl/decode_stage.sv
      - hdl/execute_stage.sv
      - hdl/result_stage.sv
      - hdl/core_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/core_props.sv
      - verification/core_tb.sv

//--- hdl/branch_predictor.sv
`default_nettype none
`include "core_macros.svh"

module branch_predictor import core_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic [`XLEN-1:0] pc,
    output logic             taken,
    input  redirect_t        train
);

    logic [1:0]            counters [`BP_ENTRIES];
    logic [`BP_IDX_W-1:0]  rd_idx;
    logic [`BP_IDX_W-1:0]  wr_idx;
    logic [1:0]            cur;

    assign rd_idx = pc[`BP_IDX_W+1:2];
    assign wr_idx = train.train_pc[`BP_IDX_W+1:2];
    assign cur    = counters[wr_idx];

    // The upper counter bit is the prediction.
    assign taken = counters[rd_idx][1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BP_ENTRIES; i++) begin
                counters[i] <= 2'b01;
            end
        end else if (train.train_valid) begin
            if (train.train_taken && cur != 2'b11) begin
                counters[wr_idx] <= cur + 2'b01;
            end else if (!train.train_taken && cur != 2'b00) begin
                counters[wr_idx] <= cur - 2'b01;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Data path and address width.
`define XLEN 32
`define REG_AW 5

// The instruction memory is loaded over the credit port before run.
`define IMEM_DEPTH 64
`define IMEM_AW 6

// The data memory is word addressed from the ALU result.
`define DMEM_DEPTH 32
`define DMEM_AW 5

// Credits granted to the program loader after reset.
`define LOAD_CREDITS 4
`define CREDIT_W 3

// The branch predictor table is indexed by PC bits 5 down to 2.
`define BP_ENTRIES 16
`define BP_IDX_W 4

`endif

//--- hdl/core_pkg.sv
`default_nettype none
`include "core_macros.svh"

package core_pkg;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_ADDI,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_JAL,
        OP_ECALL,
        OP_ILLEGAL
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic               valid;
        opcode_e            opcode;
        alu_op_e            alu_op;
        logic [`REG_AW-1:0] rs1;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   rs1_data;
        logic [`XLEN-1:0]   rs2_data;
        logic [`XLEN-1:0]   imm;
        logic [`XLEN-1:0]   pc;
        logic               predicted_taken;
        logic               reg_write;
        logic               mem_read;
        logic               mem_write;
    } ex_packet_t;

    typedef struct packed {
        logic               valid;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   alu_result;
        logic [`XLEN-1:0]   store_data;
        logic               mem_read;
        logic               mem_write;
        logic               reg_write;
        logic               halt;
    } res_packet_t;

    typedef struct packed {
        logic             mispredict;
        logic [`XLEN-1:0] target_pc;
        logic             train_valid;
        logic [`XLEN-1:0] train_pc;
        logic             train_taken;
    } redirect_t;

    // The register write is also the late forwarding source.
    typedef struct packed {
        logic               valid;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   data;
    } wb_t;

endpackage

`default_nettype wire

//--- hdl/core_top.sv
`default_nettype none
`include "core_macros.svh"

module core_top import core_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                load_valid,
    input  logic [`IMEM_AW-1:0] load_addr,
    input  logic [`XLEN-1:0]    load_data,
    output logic                load_credit,
    input  logic                run,
    output logic                retire_valid,
    output logic [`REG_AW-1:0]  retire_rd,
    output logic [`XLEN-1:0]    retire_data,
    output logic                halted
);

    logic             if_valid;
    logic [`XLEN-1:0] if_inst;
    logic [`XLEN-1:0] if_pc;
    logic             stall;
    logic             predict_taken;
    logic [`XLEN-1:0] predict_target;
    redirect_t        redirect;
    ex_packet_t       ex_pkt;
    res_packet_t      res_pkt;
    wb_t              wb;

    fetch_unit i_fetch (
        .clk,
        .rst,
        .load_valid,
        .load_addr,
        .load_data,
        .load_credit,
        .run,
        .stall,
        .predict_taken,
        .predict_target,
        .redirect,
        .halt_seen(halted),
        .if_valid,
        .if_inst,
        .if_pc
    );

    decode_stage i_decode (
        .clk,
        .rst,
        .if_valid,
        .if_inst,
        .if_pc,
        .wb,
        .redirect,
        .ex_pkt,
        .stall,
        .predict_taken,
        .predict_target
    );

    execute_stage i_execute (
        .clk,
        .rst,
        .ex_pkt,
        .wb,
        .res_pkt,
        .redirect
    );

    result_stage i_result (
        .clk,
        .rst,
        .res_pkt,
        .wb,
        .retire_valid,
        .retire_rd,
        .retire_data,
        .halted
    );

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
`default_nettype none
`include "core_macros.svh"

module decode_stage import core_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             if_valid,
    input  logic [`XLEN-1:0] if_inst,
    input  logic [`XLEN-1:0] if_pc,
    input  wb_t              wb,
    input  redirect_t        redirect,
    output ex_packet_t       ex_pkt,
    output logic             stall,
    output logic             predict_taken,
    output logic [`XLEN-1:0] predict_target
);

    opcode_e            op;
    alu_op_e            alu_op;
    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rd;
    logic [`XLEN-1:0]   rs1_data;
    logic [`XLEN-1:0]   rs2_data;
    logic [`XLEN-1:0]   imm;
    logic               is_rtype;
    logic               is_branch;
    logic               use_rs1;
    logic               use_rs2;
    logic               bp_taken;
    ex_packet_t         pkt_d;

    assign rs1 = if_inst[19:15];
    assign rs2 = if_inst[24:20];
    assign rd  = if_inst[11:7];

    register_file i_regfile (
        .clk,
        .rst,
        .rs1,
        .rs2,
        .rs1_data,
        .rs2_data,
        .wb
    );

    branch_predictor i_bp (
        .clk,
        .rst,
        .pc(if_pc),
        .taken(bp_taken),
        .train(redirect)
    );

    always_comb begin
        op = OP_ILLEGAL;
        case (if_inst[6:0])
            7'b0110011: begin
                case ({if_inst[31:25], if_inst[14:12]})
                    10'b0000000_000: op = OP_ADD;
                    10'b0100000_000: op = OP_SUB;
                    10'b0000000_111: op = OP_AND;
                    10'b0000000_110: op = OP_OR;
                    10'b0000000_100: op = OP_XOR;
                    10'b0000000_010: op = OP_SLT;
                    default:         op = OP_ILLEGAL;
                endcase
            end
            7'b0010011: if (if_inst[14:12] == 3'b000) op = OP_ADDI;
            7'b0110111: op = OP_LUI;
            7'b0000011: if (if_inst[14:12] == 3'b010) op = OP_LW;
            7'b0100011: if (if_inst[14:12] == 3'b010) op = OP_SW;
            7'b1100011: begin
                if (if_inst[14:12] == 3'b000) op = OP_BEQ;
                if (if_inst[14:12] == 3'b001) op = OP_BNE;
            end
            7'b1101111: op = OP_JAL;
            7'b1110011: if (if_inst[31:7] == '0) op = OP_ECALL;
            default:    op = OP_ILLEGAL;
        endcase
    end

    always_comb begin
        case (op)
            OP_ADDI, OP_LW: imm = {{20{if_inst[31]}}, if_inst[31:20]};
            OP_SW:  imm = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
            OP_BEQ, OP_BNE: imm = {{19{if_inst[31]}}, if_inst[31], if_inst[7],
                                   if_inst[30:25], if_inst[11:8], 1'b0};
            OP_LUI: imm = {if_inst[31:12], 12'b0};
            OP_JAL: imm = {{11{if_inst[31]}}, if_inst[31], if_inst[19:12],
                           if_inst[20], if_inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        case (op)
            OP_SUB, OP_BEQ, OP_BNE: alu_op = ALU_SUB;
            OP_AND:  alu_op = ALU_AND;
            OP_OR:   alu_op = ALU_OR;
            OP_XOR:  alu_op = ALU_XOR;
            OP_SLT:  alu_op = ALU_SLT;
            OP_LUI:  alu_op = ALU_PASS_B;
            default: alu_op = ALU_ADD;
        endcase
    end

    assign is_rtype  = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT};
    assign is_branch = op inside {OP_BEQ, OP_BNE};
    assign use_rs1   = is_rtype || is_branch || op inside {OP_ADDI, OP_LW, OP_SW};
    assign use_rs2   = is_rtype || is_branch || op == OP_SW;

    // A load in execute cannot forward in time, so its consumer waits one cycle.
    assign stall = if_valid && ex_pkt.valid && ex_pkt.mem_read && ex_pkt.rd != '0 &&
                   ((use_rs1 && rs1 == ex_pkt.rd) || (use_rs2 && rs2 == ex_pkt.rd));

    always_comb begin
        pkt_d                 = '0;
        pkt_d.valid           = if_valid && !stall && !redirect.mispredict;
        pkt_d.opcode          = op;
        pkt_d.alu_op          = alu_op;
        pkt_d.rs1             = rs1;
        pkt_d.rs2             = rs2;
        pkt_d.rd              = rd;
        pkt_d.rs1_data        = rs1_data;
        pkt_d.rs2_data        = rs2_data;
        pkt_d.imm             = imm;
        pkt_d.pc              = if_pc;
        pkt_d.predicted_taken = is_branch ? bp_taken : (op == OP_JAL);
        pkt_d.reg_write       = (is_rtype || op inside {OP_ADDI, OP_LUI, OP_LW, OP_JAL}) &&
                                rd != '0;
        pkt_d.mem_read        = (op == OP_LW);
        pkt_d.mem_write       = (op == OP_SW);
    end

    assign predict_taken  = pkt_d.valid && pkt_d.predicted_taken;
    assign predict_target = if_pc + imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_pkt.valid <= 1'b0;
        end else begin
            ex_pkt <= pkt_d;
        end
    end

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
`default_nettype none
`include "core_macros.svh"

module execute_stage import core_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  ex_packet_t  ex_pkt,
    input  wb_t         wb,
    output res_packet_t res_pkt,
    output redirect_t   redirect
);

    logic             res_fwd_ok;
    logic [`XLEN-1:0] src_a;
    logic [`XLEN-1:0] src_b;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_out;
    logic [`XLEN-1:0] link_pc;
    logic             is_cond;
    logic             taken;

    // The newer result in res_pkt takes precedence over the one in writeback.
    assign res_fwd_ok = res_pkt.valid && res_pkt.reg_write && !res_pkt.mem_read;
    assign src_a = (res_fwd_ok && res_pkt.rd == ex_pkt.rs1) ? res_pkt.alu_result :
                   (wb.valid && wb.rd == ex_pkt.rs1) ? wb.data : ex_pkt.rs1_data;
    assign src_b = (res_fwd_ok && res_pkt.rd == ex_pkt.rs2) ? res_pkt.alu_result :
                   (wb.valid && wb.rd == ex_pkt.rs2) ? wb.data : ex_pkt.rs2_data;

    assign op_b = (ex_pkt.opcode inside {OP_ADDI, OP_LUI, OP_LW, OP_SW}) ? ex_pkt.imm : src_b;
    assign link_pc = ex_pkt.pc + `XLEN'd4;

    always_comb begin
        case (ex_pkt.alu_op)
            ALU_SUB:    alu_out = src_a - op_b;
            ALU_AND:    alu_out = src_a & op_b;
            ALU_OR:     alu_out = src_a | op_b;
            ALU_XOR:    alu_out = src_a ^ op_b;
            ALU_SLT:    alu_out = {{(`XLEN-1){1'b0}}, $signed(src_a) < $signed(op_b)};
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = src_a + op_b;
        endcase
    end

    assign is_cond = ex_pkt.valid && (ex_pkt.opcode inside {OP_BEQ, OP_BNE});
    assign taken   = (ex_pkt.opcode == OP_BEQ) ? (src_a == src_b) : (src_a != src_b);

    always_comb begin
        redirect.mispredict  = is_cond && (taken != ex_pkt.predicted_taken);
        redirect.target_pc   = taken ? ex_pkt.pc + ex_pkt.imm : link_pc;
        redirect.train_valid = is_cond;
        redirect.train_pc    = ex_pkt.pc;
        redirect.train_taken = taken;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_pkt.valid <= 1'b0;
        end else begin
            res_pkt.valid      <= ex_pkt.valid;
            res_pkt.rd         <= ex_pkt.rd;
            res_pkt.alu_result <= (ex_pkt.opcode == OP_JAL) ? link_pc : alu_out;
            res_pkt.store_data <= src_b;
            res_pkt.mem_read   <= ex_pkt.mem_read;
            res_pkt.mem_write  <= ex_pkt.mem_write;
            res_pkt.reg_write  <= ex_pkt.reg_write;
            res_pkt.halt       <= (ex_pkt.opcode == OP_ECALL);
        end
    end

endmodule

`default_nettype wire

//--- hdl/fetch_unit.sv
`default_nettype none
`include "core_macros.svh"

module fetch_unit import core_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                load_valid,
    input  logic [`IMEM_AW-1:0] load_addr,
    input  logic [`XLEN-1:0]    load_data,
    output logic                load_credit,
    input  logic                run,
    input  logic                stall,
    input  logic                predict_taken,
    input  logic [`XLEN-1:0]    predict_target,
    input  redirect_t           redirect,
    input  logic                halt_seen,
    output logic                if_valid,
    output logic [`XLEN-1:0]    if_inst,
    output logic [`XLEN-1:0]    if_pc
);

    logic [`XLEN-1:0]    imem [`IMEM_DEPTH];
    logic [`XLEN-1:0]    pc;
    logic                running;
    logic [`CREDIT_W-1:0] init_credits;

    // A returned credit owns its cycle, so an initial grant waits for a free one.
    always_ff @(posedge clk) begin
        if (rst) begin
            init_credits <= `CREDIT_W'(`LOAD_CREDITS);
            load_credit  <= 1'b0;
        end else begin
            load_credit <= load_valid || (init_credits != '0);
            if (!load_valid && init_credits != '0) begin
                init_credits <= init_credits - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_valid) begin
            imem[load_addr] <= load_data;
        end
    end

    // Mispredict wins over a decode prediction, which wins over the next word.
    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= '0;
            running  <= 1'b0;
            if_valid <= 1'b0;
        end else if (run) begin
            pc       <= '0;
            running  <= 1'b1;
            if_valid <= 1'b0;
        end else if (redirect.mispredict) begin
            pc       <= redirect.target_pc;
            if_valid <= 1'b0;
        end else if (!stall) begin
            if (predict_taken) begin
                pc       <= predict_target;
                if_valid <= 1'b0;
            end else if (running && !halt_seen) begin
                if_inst  <= imem[pc[`IMEM_AW+1:2]];
                if_pc    <= pc;
                if_valid <= 1'b1;
                pc       <= pc + `XLEN'd4;
            end else begin
                if_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/register_file.sv
`default_nettype none
`include "core_macros.svh"

module register_file import core_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [`REG_AW-1:0] rs1,
    input  logic [`REG_AW-1:0] rs2,
    output logic [`XLEN-1:0]   rs1_data,
    output logic [`XLEN-1:0]   rs2_data,
    input  wb_t                wb
);

    logic [`XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // The value being written this cycle is returned to a matching read.
    assign rs1_data = (rs1 == '0) ? '0 :
                      (wb.valid && wb.rd == rs1) ? wb.data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (wb.valid && wb.rd == rs2) ? wb.data : regs[rs2];

endmodule

`default_nettype wire

//--- hdl/result_stage.sv
`default_nettype none
`include "core_macros.svh"

module result_stage import core_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  res_packet_t        res_pkt,
    output wb_t                wb,
    output logic               retire_valid,
    output logic [`REG_AW-1:0] retire_rd,
    output logic [`XLEN-1:0]   retire_data,
    output logic               halted
);

    logic [`XLEN-1:0]    dmem [`DMEM_DEPTH];
    logic [`DMEM_AW-1:0] dmem_idx;
    logic [`XLEN-1:0]    result;
    logic                live;

    // Nothing behind the ECALL may change state.
    assign live     = res_pkt.valid && !halted;
    assign dmem_idx = res_pkt.alu_result[`DMEM_AW+1:2];
    assign result   = res_pkt.mem_read ? dmem[dmem_idx] : res_pkt.alu_result;

    always_ff @(posedge clk) begin
        if (live && res_pkt.mem_write) begin
            dmem[dmem_idx] <= res_pkt.store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb.valid     <= 1'b0;
            retire_valid <= 1'b0;
            halted       <= 1'b0;
        end else begin
            wb.valid     <= live && res_pkt.reg_write;
            retire_valid <= live && !res_pkt.halt;
            if (res_pkt.valid && res_pkt.halt) begin
                halted <= 1'b1;
            end
        end
        wb.rd   <= res_pkt.rd;
        wb.data <= result;
        // Stores report the stored word; other non-writing instructions report zero.
        retire_rd   <= res_pkt.reg_write ? res_pkt.rd : '0;
        retire_data <= res_pkt.mem_write ? res_pkt.store_data :
                       res_pkt.reg_write ? result : '0;
    end

endmodule

`default_nettype wire

//--- verification/core_props.sv
`default_nettype none
`include "core_macros.svh"

module core_props (
    input logic clk,
    input logic rst,
    input logic load_valid,
    input logic load_credit,
    input logic retire_valid,
    input logic halted
);

    timeunit 1ns;
    timeprecision 100ps;

    int credit_count;
    int fail_count = 0;

    // Credits held by the sender, as seen from the core side of the port.
    always @(posedge clk) begin
        if (rst) begin
            credit_count <= 0;
        end else begin
            credit_count <= credit_count + int'(load_credit) - int'(load_valid);
        end
    end

    credit_overdraft: assert property (@(posedge clk) disable iff (rst)
        load_valid |-> credit_count > 0)
        else begin
            $error("Load word sent without a credit");
            fail_count++;
        end

    credit_limit: assert property (@(posedge clk) disable iff (rst)
        credit_count <= `LOAD_CREDITS)
        else begin
            $error("Sender holds more credits than the core grants");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        rst |=> !load_credit && !retire_valid && !halted)
        else begin
            $error("Core outputs active during reset");
            fail_count++;
        end

    no_retire_halted: assert property (@(posedge clk) disable iff (rst)
        !(retire_valid && halted))
        else begin
            $error("Retire while halted");
            fail_count++;
        end

    halt_sticky: assert property (@(posedge clk) disable iff (rst)
        halted |=> halted)
        else begin
            $error("Halted dropped without reset");
            fail_count++;
        end

endmodule

bind core_top core_props i_props (
    .clk(clk),
    .rst(rst),
    .load_valid(load_valid),
    .load_credit(load_credit),
    .retire_valid(retire_valid),
    .halted(halted)
);

`default_nettype wire

//--- verification/core_tb.sv
`default_nettype none
`include "core_macros.svh"

module core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROG_LEN        = 29;
    localparam int RESET_CYCLES    = 10;
    localparam int LOAD_BUDGET     = PROG_LEN * 8;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + LOAD_BUDGET + PROG_LEN * 20;
    localparam logic [6:0] IMM_OPC  = 7'b0010011;
    localparam logic [6:0] LOAD_OPC = 7'b0000011;

    typedef struct packed {
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   data;
    } retire_rec_t;

    logic                clk;
    logic                rst;
    logic                load_valid;
    logic [`IMEM_AW-1:0] load_addr;
    logic [`XLEN-1:0]    load_data;
    logic                load_credit;
    logic                run;
    logic                retire_valid;
    logic [`REG_AW-1:0]  retire_rd;
    logic [`XLEN-1:0]    retire_data;
    logic                halted;

    logic [`XLEN-1:0] prog [PROG_LEN];
    retire_rec_t      expected [$];
    int               credits_got = 0;
    int               credits_spent = 0;
    logic [15:0]      lfsr;

    core_top i_dut (.*);

    function automatic logic [15:0] lfsr_next(logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    function automatic logic [31:0] rtype(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] itype(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] stype(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] btype(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jtype(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] want);
        assert (got === want)
            else fail_run($sformatf("Mismatch at %0t ns: %s expected 0x%08h, got 0x%08h",
                                    $time, name, want, got));
    endtask

    task automatic write_program();
        prog[0]  = {20'h12345, 5'd1, 7'b0110111};
        prog[1]  = itype(12'h678, 5'd1, 3'b000, 5'd2, IMM_OPC);
        prog[2]  = rtype(7'h00, 5'd1, 5'd2, 3'b000, 5'd3);
        prog[3]  = rtype(7'h20, 5'd2, 5'd3, 3'b000, 5'd4);
        prog[4]  = rtype(7'h00, 5'd3, 5'd4, 3'b100, 5'd5);
        prog[5]  = rtype(7'h00, 5'd2, 5'd5, 3'b111, 5'd6);
        prog[6]  = rtype(7'h00, 5'd1, 5'd6, 3'b110, 5'd7);
        prog[7]  = rtype(7'h00, 5'd7, 5'd1, 3'b010, 5'd8);
        prog[8]  = itype(12'hFFB, 5'd0, 3'b000, 5'd9, IMM_OPC);
        prog[9]  = rtype(7'h00, 5'd8, 5'd9, 3'b010, 5'd10);
        // Each stored word is reloaded, and the very next instruction uses the reload.
        prog[10] = stype(12'd8, 5'd7, 5'd0);
        prog[11] = itype(12'd8, 5'd0, 3'b010, 5'd11, LOAD_OPC);
        prog[12] = rtype(7'h00, 5'd9, 5'd11, 3'b000, 5'd12);
        prog[13] = stype(12'd12, 5'd12, 5'd0);
        prog[14] = itype(12'd12, 5'd0, 3'b010, 5'd13, LOAD_OPC);
        prog[15] = rtype(7'h00, 5'd13, 5'd9, 3'b000, 5'd14);
        // BNE closes a loop back to the add that counts down from four.
        prog[16] = itype(12'd4, 5'd0, 3'b000, 5'd15, IMM_OPC);
        prog[17] = itype(12'd0, 5'd0, 3'b000, 5'd16, IMM_OPC);
        prog[18] = rtype(7'h00, 5'd15, 5'd16, 3'b000, 5'd16);
        prog[19] = itype(12'hFFF, 5'd15, 3'b000, 5'd15, IMM_OPC);
        prog[20] = btype(13'h1FF8, 5'd0, 5'd15, 3'b001);
        prog[21] = btype(13'd8, 5'd16, 5'd15, 3'b000);
        prog[22] = jtype(21'd8, 5'd17);
        prog[23] = itype(12'd99, 5'd0, 3'b000, 5'd18, IMM_OPC);
        prog[24] = itype(12'd1, 5'd17, 3'b000, 5'd19, IMM_OPC);
        prog[25] = 32'h00000073;
        for (int i = 26; i < PROG_LEN; i++) begin
            prog[i] = itype(12'd0, 5'd0, 3'b000, 5'd0, IMM_OPC);
        end
    endtask

    // In-order ISA model that lists the result of every instruction before the ECALL.
    task automatic build_expected();
        logic [31:0] regs [32];
        logic [31:0] mem [`DMEM_DEPTH];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic [31:0] addr;
        logic        wr;
        int          idx;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc = '0;
        for (int step = 0; step < 1000; step++) begin
            idx = int'(pc >> 2);
            if (idx >= PROG_LEN || prog[idx] == 32'h00000073) begin
                break;
            end
            inst    = prog[idx];
            a       = regs[inst[19:15]];
            b       = regs[inst[24:20]];
            val     = '0;
            wr      = 1'b0;
            next_pc = pc + 32'd4;
            case (inst[6:0])
                7'b0110011: begin
                    wr = 1'b1;
                    case (inst[14:12])
                        3'b000:  val = inst[30] ? a - b : a + b;
                        3'b111:  val = a & b;
                        3'b110:  val = a | b;
                        3'b100:  val = a ^ b;
                        3'b010:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: val = '0;
                    endcase
                end
                IMM_OPC: begin
                    wr  = 1'b1;
                    val = a + {{20{inst[31]}}, inst[31:20]};
                end
                7'b0110111: begin
                    wr  = 1'b1;
                    val = {inst[31:12], 12'b0};
                end
                LOAD_OPC: begin
                    addr = a + {{20{inst[31]}}, inst[31:20]};
                    wr   = 1'b1;
                    val  = mem[(addr >> 2) % `DMEM_DEPTH];
                end
                7'b0100011: begin
                    addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                    mem[(addr >> 2) % `DMEM_DEPTH] = b;
                    val = b;
                end
                7'b1100011: begin
                    if ((inst[14:12] == 3'b000) ? (a == b) : (a != b)) begin
                        next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                        inst[11:8], 1'b0};
                    end
                end
                7'b1101111: begin
                    wr      = 1'b1;
                    val     = pc + 32'd4;
                    next_pc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                    inst[30:21], 1'b0};
                end
                default: val = '0;
            endcase
            if (wr && inst[11:7] != '0) begin
                regs[inst[11:7]] = val;
                expected.push_back({inst[11:7], val});
            end else if (wr) begin
                expected.push_back('0);
            end else begin
                expected.push_back({5'd0, val});
            end
            pc = next_pc;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        if (!rst && load_credit) begin
            credits_got++;
        end
        assert (credits_got - credits_spent <= `LOAD_CREDITS)
            else fail_run("The core returned more load credits than it granted");
    end

    always @(negedge clk) begin
        retire_rec_t want;
        if (!rst && retire_valid) begin
            if (expected.size() == 0) begin
                fail_run("An instruction retired after the last expected result");
            end else begin
                want = expected.pop_front();
                check_value("retire_rd", 32'(retire_rd), 32'(want.rd));
                check_value("retire_data", retire_data, want.data);
            end
        end
    end

    always @(negedge clk) begin
        if (i_dut.i_props.fail_count != 0) begin
            fail_run("A bound assertion on the core ports failed");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run("Timeout: the core did not halt within the cycle budget");
    end

    initial begin
        logic send;
        int   idx;
        rst        = 1'b1;
        load_valid = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        run        = 1'b0;
        lfsr       = 16'd48331;
        idx        = 0;
        write_program();
        build_expected();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // One LFSR bit per cycle decides whether a word goes out, if a credit is held.
        while (idx < PROG_LEN) begin
            @(posedge clk);
            send = lfsr[0];
            lfsr = lfsr_next(lfsr);
            if (send && credits_got > credits_spent) begin
                load_valid <= 1'b1;
                load_addr  <= idx[`IMEM_AW-1:0];
                load_data  <= prog[idx];
                credits_spent++;
                idx++;
            end else begin
                load_valid <= 1'b0;
            end
        end
        @(posedge clk);
        load_valid <= 1'b0;

        while (credits_got - credits_spent != `LOAD_CREDITS) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);

        @(posedge clk);
        run <= 1'b1;
        @(posedge clk);
        run <= 1'b0;
        while (!halted) begin
            @(negedge clk);
        end
        repeat (6) @(negedge clk);
        if (expected.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            fail_run($sformatf("Core halted with %0d expected results not retired",
                               expected.size()));
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+hdl
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/register_file.sv
hdl/branch_predictor.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/core_top.sv
verification/core_props.sv
verification/core_tb.sv
